// File: tb.f
common/dallanma_pkg.sv
hdl/buyruk_cozucu.sv
hdl/karsilastirici.sv
dallanma/dallanma_birimi.sv
hdl/dallanma_ust.sv
tests/dallanma_asserts.sv
tests/tb_dallanma.sv

// File: Makefile
TOP = tb_dallanma

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_dallanma.sv
`timescale 1ns/1ps

module tb_dallanma;

    // opcode and funct3 together
    localparam logic [9:0] BEQ     = {7'b1100011, 3'b000};
    localparam logic [9:0] BNE     = {7'b1100011, 3'b001};
    localparam logic [9:0] BLT     = {7'b1100011, 3'b100};
    localparam logic [9:0] BGE     = {7'b1100011, 3'b101};
    localparam logic [9:0] BLTU    = {7'b1100011, 3'b110};
    localparam logic [9:0] BGEU    = {7'b1100011, 3'b111};
    localparam logic [9:0] B_010   = {7'b1100011, 3'b010};  // reserved funct3
    localparam logic [9:0] B_011   = {7'b1100011, 3'b011};
    localparam logic [9:0] ALU_ADD = {7'b0110011, 3'b000};  // not a branch

    localparam int RASTGELE_SAYI  = 48;
    localparam int BOSALMA_SINIRI = 200;
    localparam int DURMA_SINIRI   = 8;

    typedef struct packed {
        logic [9:0]  tur;
        logic [12:0] imm;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] ps;
        logic        ongoru;
        logic        atladi;  // expected from here on
        logic [31:0] hedef;
        logic        hata;
    } satir_s;

    typedef struct packed {
        logic        atladi;
        logic        hata;
        logic [31:0] hedef;
        logic [31:0] ps;
    } beklenen_s;

    logic        clk;
    logic        rst;
    logic        durdur;
    logic        gecerli;
    logic [31:0] buyruk;
    logic [31:0] ps;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        ongoru;
    logic        guncelle_gecerli;
    logic        guncelle_atladi;
    logic        dallanma_hata;
    logic [31:0] guncelle_hedef;
    logic [31:0] guncelle_ps;

    satir_s      tablo [0:31];
    int          tablo_boy = 0;
    beklenen_s   kuyruk [$];
    logic [31:0] lfsr_durum = 32'hf70df2a3;
    int          deger_hata = 0;
    int          diger_hata = 0;

    dallanma_ust UUT (
        .clk_i                   (clk),
        .rst_i                   (rst),
        .durdur_i                (durdur),
        .gecerli_i               (gecerli),
        .buyruk_i                (buyruk),
        .ps_i                    (ps),
        .rs1_i                   (rs1),
        .rs2_i                   (rs2),
        .ongoru_i                (ongoru),
        .guncelle_gecerli_o      (guncelle_gecerli),
        .guncelle_atladi_o       (guncelle_atladi),
        .dallanma_hata_o         (dallanma_hata),
        .guncelle_hedef_adresi_o (guncelle_hedef),
        .guncelle_ps_o           (guncelle_ps)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_adim();
        logic geri;
        geri       = lfsr_durum[31] ^ lfsr_durum[21] ^ lfsr_durum[1] ^ lfsr_durum[0];
        lfsr_durum = {lfsr_durum[30:0], geri};
        return geri;
    endfunction

    function automatic logic [31:0] rastgele(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_adim()};
        end
        return r;
    endfunction

    // B-type word with rs1 = x1, rs2 = x2
    function automatic logic [31:0] buyruk_kodla(input logic [9:0] tur, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, tur[2:0], imm[4:1], imm[11], tur[9:3]};
    endfunction

    function automatic logic dal_mi(input logic [9:0] tur);
        return (tur[9:3] == 7'b1100011) && (tur[2:1] != 2'b01);
    endfunction

    // reference rules for the random pass
    function automatic logic atlar_mi(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] hedef_hesapla(input logic atla, input logic [31:0] adres,
                                                  input logic [12:0] imm);
        return atla ? adres + {{19{imm[12]}}, imm} : adres + 32'd4;
    endfunction

    task automatic satir_ekle(input logic [9:0] tur, input logic [12:0] imm,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] adres, input logic tahmin, input logic atla,
                              input logic [31:0] hedef, input logic hata);
        tablo[tablo_boy] = '{tur, imm, a, b, adres, tahmin, atla, hedef, hata};
        tablo_boy++;
    endtask

    task automatic tablo_doldur();
        // kind, imm, rs1, rs2, ps, prediction, then expected taken, target, mispredict
        satir_ekle(BEQ, 13'h008, 32'h5, 32'h5, 32'h100, 1'b1, 1'b1, 32'h108, 1'b0);
        satir_ekle(BEQ, 13'h008, 32'h5, 32'h6, 32'h110, 1'b1, 1'b0, 32'h114, 1'b1);
        satir_ekle(BNE, 13'h1ffc, 32'h7, 32'h7, 32'h120, 1'b0, 1'b0, 32'h124, 1'b0);
        satir_ekle(BNE, 13'h1ffc, 32'hffffffff, 32'h1, 32'h130, 1'b0, 1'b1, 32'h12c, 1'b1);
        satir_ekle(BLT, 13'h010, 32'h5, 32'h5, 32'h140, 1'b1, 1'b0, 32'h144, 1'b1);
        satir_ekle(BLT, 13'h010, 32'hffffffff, 32'h1, 32'h150, 1'b1, 1'b1, 32'h160, 1'b0);
        satir_ekle(BLT, 13'h010, 32'h1, 32'hffffffff, 32'h160, 1'b0, 1'b0, 32'h164, 1'b0);
        satir_ekle(BLT, 13'h010, 32'h80000000, 32'h7fffffff, 32'h170, 1'b0, 1'b1, 32'h180, 1'b1);
        satir_ekle(BGE, 13'h020, 32'h5, 32'h5, 32'h180, 1'b1, 1'b1, 32'h1a0, 1'b0);
        satir_ekle(BGE, 13'h020, 32'hffffffff, 32'h1, 32'h190, 1'b1, 1'b0, 32'h194, 1'b1);
        satir_ekle(BGE, 13'h020, 32'h7fffffff, 32'h80000000, 32'h1a0, 1'b0, 1'b1, 32'h1c0, 1'b1);
        satir_ekle(BLTU, 13'h040, 32'h5, 32'h5, 32'h1b0, 1'b0, 1'b0, 32'h1b4, 1'b0);
        satir_ekle(BLTU, 13'h040, 32'hffffffff, 32'h1, 32'h1c0, 1'b1, 1'b0, 32'h1c4, 1'b1);
        satir_ekle(BLTU, 13'h040, 32'h1, 32'hffffffff, 32'h1d0, 1'b1, 1'b1, 32'h210, 1'b0);
        satir_ekle(BGEU, 13'h0ffe, 32'hffffffff, 32'h1, 32'h1e0, 1'b1, 1'b1, 32'h11de, 1'b0);
        satir_ekle(BGEU, 13'h1000, 32'h0, 32'h0, 32'h2000, 1'b0, 1'b1, 32'h1000, 1'b1);
        satir_ekle(BGEU, 13'h1000, 32'h0, 32'h1, 32'h2010, 1'b0, 1'b0, 32'h2014, 1'b0);
        satir_ekle(ALU_ADD, 13'h000, 32'h1, 32'h1, 32'h2020, 1'b1, 1'b0, 32'h0, 1'b0);
        satir_ekle(B_010, 13'h008, 32'h5, 32'h5, 32'h2030, 1'b1, 1'b0, 32'h0, 1'b0);
        satir_ekle(B_011, 13'h008, 32'h5, 32'h5, 32'h2040, 1'b0, 1'b0, 32'h0, 1'b0);
        satir_ekle(BEQ, 13'h1ffe, 32'h80000000, 32'h80000000, 32'h2050, 1'b0, 1'b1, 32'h204e, 1'b1);
        satir_ekle(BNE, 13'h1000, 32'h0, 32'h1, 32'h800, 1'b1, 1'b1, 32'hfffff800, 1'b0);
    endtask

    task automatic beklenen_ekle(input logic atla, input logic hata, input logic [31:0] hedef,
                                 input logic [31:0] adres);
        beklenen_s b;
        b.atladi = atla;
        b.hata   = hata;
        b.hedef  = hedef;
        b.ps     = adres;
        kuyruk.push_back(b);
    endtask

    // presents a word until an edge without stall takes it
    task automatic kelime_sur(input logic [31:0] kelime, input logic [31:0] adres,
                              input logic [31:0] a, input logic [31:0] b, input logic tahmin);
        logic [31:0] rnd;
        logic        dur;
        int          deneme;
        deneme = 0;
        do begin
            rnd = rastgele(2);
            dur = (rnd[1:0] == 2'b11) && (deneme < DURMA_SINIRI);
            @(posedge clk);
            durdur  <= dur;
            gecerli <= 1'b1;
            buyruk  <= kelime;
            ps      <= adres;
            rs1     <= a;
            rs2     <= b;
            ongoru  <= tahmin;
            deneme++;
        end while (dur);
    endtask

    task automatic deger_denetle(input string ad, input logic [31:0] gelen,
                                 input logic [31:0] beklenen);
        assert (gelen == beklenen) else begin
            deger_hata++;
            $display("ERR %0t %s got %h expected %h", $time, ad, gelen, beklenen);
        end
    endtask

    always @(posedge clk) begin
        beklenen_s bek;
        if (rst && guncelle_gecerli) begin
            if (kuyruk.size() == 0) begin
                diger_hata++;
                $display("update at %0t with no branch pending", $time);
            end else begin
                bek = kuyruk.pop_front();
                deger_denetle("guncelle_atladi_o", {31'd0, guncelle_atladi}, {31'd0, bek.atladi});
                deger_denetle("dallanma_hata_o", {31'd0, dallanma_hata}, {31'd0, bek.hata});
                deger_denetle("guncelle_hedef_adresi_o", guncelle_hedef, bek.hedef);
                deger_denetle("guncelle_ps_o", guncelle_ps, bek.ps);
            end
        end else if (rst) begin
            assert (!guncelle_atladi && !dallanma_hata) else begin
                diger_hata++;
                $display("taken or mispredict flag high without an update at %0t", $time);
            end
        end
    end

    initial begin
        int          i;
        int          bekleme;
        logic [31:0] rnd;
        logic [9:0]  tur;
        logic [12:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] adres;
        logic        tahmin;
        logic        atla;

        rst     = 1'b0;
        durdur  = 1'b0;
        gecerli = 1'b0;
        buyruk  = '0;
        ps      = '0;
        rs1     = '0;
        rs2     = '0;
        ongoru  = 1'b0;
        tablo_doldur();

        repeat (16) @(posedge clk);
        rst <= 1'b1;

        // nothing sent yet, flags stay low
        repeat (5) begin
            @(posedge clk);
            assert (!guncelle_gecerli && !guncelle_atladi && !dallanma_hata) else begin
                diger_hata++;
                $display("flag output high after reset with no input at %0t", $time);
            end
        end

        for (i = 0; i < tablo_boy; i++) begin
            kelime_sur(buyruk_kodla(tablo[i].tur, tablo[i].imm), tablo[i].ps,
                       tablo[i].rs1, tablo[i].rs2, tablo[i].ongoru);
            if (dal_mi(tablo[i].tur)) begin
                beklenen_ekle(tablo[i].atladi, tablo[i].hata, tablo[i].hedef, tablo[i].ps);
            end
        end

        // random operands, funct3 010/011 show up as reserved words
        for (i = 0; i < RASTGELE_SAYI; i++) begin
            rnd    = rastgele(3);
            tur    = {7'b1100011, rnd[2:0]};
            rnd    = rastgele(12);
            imm    = {rnd[11:0], 1'b0};
            a      = rastgele(32);
            rnd    = rastgele(2);
            b      = (rnd[1:0] == 2'b00) ? a : rastgele(32);
            rnd    = rastgele(1);
            tahmin = rnd[0];
            adres  = 32'h00010000 + (i * 16);
            atla   = atlar_mi(tur[2:0], a, b);
            kelime_sur(buyruk_kodla(tur, imm), adres, a, b, tahmin);
            if (dal_mi(tur)) begin
                beklenen_ekle(atla, tahmin != atla, hedef_hesapla(atla, adres, imm), adres);
            end
        end

        @(posedge clk);
        gecerli <= 1'b0;
        durdur  <= 1'b0;

        bekleme = 0;
        while (kuyruk.size() != 0 && bekleme < BOSALMA_SINIRI) begin
            @(posedge clk);
            bekleme++;
        end
        if (kuyruk.size() != 0) begin
            diger_hata++;
            $display("timeout, %0d branch updates never arrived", kuyruk.size());
        end
        repeat (4) @(posedge clk); // room for a stray extra pulse

        $display("errors: value %0d, other %0d, assertion %0d",
                 deger_hata, diger_hata, UUT.u_asserts.hata_sayisi);
        if (deger_hata + diger_hata + UUT.u_asserts.hata_sayisi == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tests/dallanma_asserts.sv
`timescale 1ns/1ps

module dallanma_asserts (
    input logic                clk_i,
    input logic                rst_i,
    input logic                durdur_i,
    input logic                guncelle_gecerli_i,
    input logic                guncelle_atladi_i,
    input logic                dallanma_hata_i,
    input dallanma_pkg::veri_t guncelle_ps_i
);

    int   hata_sayisi = 0;
    logic bayrak_yok;

    assign bayrak_yok = !guncelle_gecerli_i && !guncelle_atladi_i && !dallanma_hata_i;

    // back to back pulses must come from different branches
    assert property (@(posedge clk_i) disable iff (!rst_i)
        guncelle_gecerli_i && $past(guncelle_gecerli_i) |-> guncelle_ps_i != $past(guncelle_ps_i))
    else begin
        $error("update pulse held for the same branch");
        hata_sayisi++;
    end

    // a stalled edge never produces an update
    assert property (@(posedge clk_i) disable iff (!rst_i)
        guncelle_gecerli_i |-> !$past(durdur_i))
    else begin
        $error("update emitted after a stalled edge");
        hata_sayisi++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_i)
        dallanma_hata_i |-> guncelle_gecerli_i)
    else begin
        $error("misprediction flag without an update");
        hata_sayisi++;
    end

    // pipe is empty for the first cycles after release
    assert property (@(posedge clk_i)
        rst_i && (!$past(rst_i, 1) || !$past(rst_i, 2) || !$past(rst_i, 3)) |-> bayrak_yok)
    else begin
        $error("flag output high right after reset release");
        hata_sayisi++;
    end

endmodule

bind dallanma_ust dallanma_asserts u_asserts (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .durdur_i           (durdur_i),
    .guncelle_gecerli_i (guncelle_gecerli_o),
    .guncelle_atladi_i  (guncelle_atladi_o),
    .dallanma_hata_i    (dallanma_hata_o),
    .guncelle_ps_i      (guncelle_ps_o)
);

// File: hdl/dallanma_ust.sv
`timescale 1ns/1ps

module dallanma_ust (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  durdur_i,  // global stall
    input  logic                  gecerli_i,
    input  dallanma_pkg::buyruk_t buyruk_i,
    input  dallanma_pkg::veri_t   ps_i,
    input  dallanma_pkg::veri_t   rs1_i,
    input  dallanma_pkg::veri_t   rs2_i,
    input  logic                  ongoru_i,  // 1 = predicted taken
    output logic                  guncelle_gecerli_o,
    output logic                  guncelle_atladi_o,
    output logic                  dallanma_hata_o,
    output dallanma_pkg::veri_t   guncelle_hedef_adresi_o,
    output dallanma_pkg::veri_t   guncelle_ps_o
);

    dallanma_pkg::coz_cikis_s   coz;
    dallanma_pkg::yurut_cikis_s yurut;

    // decode
    buyruk_cozucu u_coz (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .durdur_i  (durdur_i),
        .gecerli_i (gecerli_i),
        .buyruk_i  (buyruk_i),
        .ps_i      (ps_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .ongoru_i  (ongoru_i),
        .coz_o     (coz)
    );

    // execute, comparison flags
    karsilastirici u_kars (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .durdur_i (durdur_i),
        .coz_i    (coz),
        .yurut_o  (yurut)
    );

    // result, predictor update
    dallanma_birimi u_dal (
        .clk_i                   (clk_i),
        .rst_i                   (rst_i),
        .durdur_i                (durdur_i),
        .yurut_i                 (yurut),
        .guncelle_gecerli_o      (guncelle_gecerli_o),
        .guncelle_atladi_o       (guncelle_atladi_o),
        .dallanma_hata_o         (dallanma_hata_o),
        .guncelle_hedef_adresi_o (guncelle_hedef_adresi_o),
        .guncelle_ps_o           (guncelle_ps_o)
    );

endmodule

// File: dallanma/dallanma_birimi.sv
`timescale 1ns/1ps

module dallanma_birimi (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       durdur_i,
    input  dallanma_pkg::yurut_cikis_s yurut_i,
    output logic                       guncelle_gecerli_o,
    output logic                       guncelle_atladi_o,
    output logic                       dallanma_hata_o,
    output dallanma_pkg::veri_t        guncelle_hedef_adresi_o, // fetch restarts here on a miss
    output dallanma_pkg::veri_t        guncelle_ps_o
);

    localparam dallanma_pkg::veri_t BUYRUK_ADIM = 32'd4; // next sequential word

    logic                guncelle;
    logic                atladi;
    logic                buyuk_esit;
    logic                buyuk_esit_u;
    dallanma_pkg::veri_t hedef;

    logic                gecerli_r;
    logic                atladi_r;
    logic                hata_r;
    dallanma_pkg::veri_t hedef_r;
    dallanma_pkg::veri_t ps_r;

    assign guncelle = yurut_i.gecerli && yurut_i.blok_aktif;

    // less than means neither greater nor equal
    assign buyuk_esit   = yurut_i.buyuk_mu || yurut_i.esit_mi;
    assign buyuk_esit_u = yurut_i.buyuk_mu_unsigned || yurut_i.esit_mi;

    always_comb begin
        case (yurut_i.dal_buy_turu)
            dallanma_pkg::BRA_BEQ:  atladi = yurut_i.esit_mi;
            dallanma_pkg::BRA_BNE:  atladi = !yurut_i.esit_mi;
            dallanma_pkg::BRA_BLT:  atladi = !buyuk_esit;
            dallanma_pkg::BRA_BGE:  atladi = buyuk_esit;
            dallanma_pkg::BRA_BLTU: atladi = !buyuk_esit_u;
            dallanma_pkg::BRA_BGEU: atladi = buyuk_esit_u;
            default:                atladi = 1'b0; // blocked by blok_aktif anyway
        endcase
    end

    // corrected fetch address for either outcome
    always_comb begin
        if (atladi) begin
            hedef = yurut_i.ps + yurut_i.br;
        end else begin
            hedef = yurut_i.ps + BUYRUK_ADIM;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            gecerli_r <= 1'b0;
            atladi_r  <= 1'b0;
            hata_r    <= 1'b0;
            hedef_r   <= '0;
            ps_r      <= '0;
        end else if (durdur_i) begin
            // stalled edge, drop the pulse so nothing is reported twice
            gecerli_r <= 1'b0;
            atladi_r  <= 1'b0;
            hata_r    <= 1'b0;
        end else begin
            gecerli_r <= guncelle;
            atladi_r  <= guncelle && atladi;
            hata_r    <= guncelle && (yurut_i.ongoru != atladi); // prediction missed
            if (guncelle) begin
                hedef_r <= hedef;
                ps_r    <= yurut_i.ps; // branch's own pc for the predictor
            end
        end
    end

    assign guncelle_gecerli_o      = gecerli_r;
    assign guncelle_atladi_o       = atladi_r;
    assign dallanma_hata_o         = hata_r;
    assign guncelle_hedef_adresi_o = hedef_r;
    assign guncelle_ps_o           = ps_r;

endmodule

// File: hdl/karsilastirici.sv
`timescale 1ns/1ps

module karsilastirici (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       durdur_i,
    input  dallanma_pkg::coz_cikis_s   coz_i,
    output dallanma_pkg::yurut_cikis_s yurut_o
);

    logic                       esit;
    logic                       buyuk_isaretli;
    logic                       buyuk_isaretsiz;
    dallanma_pkg::yurut_cikis_s yurut_d;
    dallanma_pkg::yurut_cikis_s yurut_r;

    // same three flags the core ALU hands to the branch unit
    assign esit            = (coz_i.rs1 == coz_i.rs2);
    assign buyuk_isaretli  = ($signed(coz_i.rs1) > $signed(coz_i.rs2));
    assign buyuk_isaretsiz = (coz_i.rs1 > coz_i.rs2);

    always_comb begin
        // control and address fields pass through unchanged
        yurut_d.gecerli           = coz_i.gecerli;
        yurut_d.blok_aktif        = coz_i.blok_aktif;
        yurut_d.dal_buy_turu      = coz_i.dal_buy_turu;
        yurut_d.ongoru            = coz_i.ongoru;
        yurut_d.ps                = coz_i.ps;
        yurut_d.br                = coz_i.br;
        yurut_d.esit_mi           = esit;
        yurut_d.buyuk_mu          = buyuk_isaretli;
        yurut_d.buyuk_mu_unsigned = buyuk_isaretsiz;
    end

    always_ff @(posedge clk_i) begin
        if (!durdur_i) begin
            yurut_r <= yurut_d;
        end
        if (!rst_i) begin
            yurut_r.gecerli <= 1'b0;
        end
    end

    assign yurut_o = yurut_r;

endmodule

// File: hdl/buyruk_cozucu.sv
`timescale 1ns/1ps

module buyruk_cozucu (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     durdur_i,
    input  logic                     gecerli_i,
    input  dallanma_pkg::buyruk_t    buyruk_i,
    input  dallanma_pkg::veri_t      ps_i,
    input  dallanma_pkg::veri_t      rs1_i,
    input  dallanma_pkg::veri_t      rs2_i,
    input  logic                     ongoru_i,
    output dallanma_pkg::coz_cikis_s coz_o
);

    logic [6:0]               opkod;
    logic [2:0]               funct3;
    logic                     dal_mi;
    dallanma_pkg::veri_t      imm_b;
    dallanma_pkg::coz_cikis_s coz_d;
    dallanma_pkg::coz_cikis_s coz_r;

    assign opkod  = buyruk_i[6:0];
    assign funct3 = buyruk_i[14:12];

    // 010 and 011 are unused under the branch opcode
    always_comb begin
        dal_mi = 1'b0;
        if (opkod == dallanma_pkg::BRANCH_OPCODE) begin
            case (funct3)
                3'b010,
                3'b011:  dal_mi = 1'b0;
                default: dal_mi = 1'b1;
            endcase
        end
    end

    // B-type immediate, bit 0 is always zero
    assign imm_b = {
        {19{buyruk_i[31]}}, // sign
        buyruk_i[31],       // imm[12]
        buyruk_i[7],        // imm[11]
        buyruk_i[30:25],    // imm[10:5]
        buyruk_i[11:8],     // imm[4:1]
        1'b0
    };

    always_comb begin
        coz_d.gecerli      = gecerli_i;
        coz_d.blok_aktif   = dal_mi;
        coz_d.dal_buy_turu = dallanma_pkg::dal_tur_e'(funct3); // kind is funct3 itself
        coz_d.ongoru       = ongoru_i;
        coz_d.ps           = ps_i;
        coz_d.br           = imm_b;
        coz_d.rs1          = rs1_i;
        coz_d.rs2          = rs2_i;
    end

    // stage register, held while the pipe is stalled
    always_ff @(posedge clk_i) begin
        if (!durdur_i) begin
            coz_r <= coz_d;
        end
        if (!rst_i) begin
            coz_r.gecerli <= 1'b0; // only the valid bit needs clearing
        end
    end

    assign coz_o = coz_r;

endmodule

// File: common/dallanma_pkg.sv
package dallanma_pkg;

    // register value or address
    typedef logic [31:0] veri_t;

    // raw instruction word
    typedef logic [31:0] buyruk_t;

    // branch kinds, encoded exactly as funct3
    typedef enum logic [2:0] {
        BRA_BEQ  = 3'b000,
        BRA_BNE  = 3'b001,
        BRA_BLT  = 3'b100,
        BRA_BGE  = 3'b101,
        BRA_BLTU = 3'b110,
        BRA_BGEU = 3'b111
    } dal_tur_e;

    localparam logic [6:0] BRANCH_OPCODE = 7'b1100011; // B-type major opcode

    // decode -> execute
    typedef struct packed {
        logic     gecerli;       // slot holds an accepted word
        logic     blok_aktif;    // word is a legal conditional branch
        dal_tur_e dal_buy_turu;
        logic     ongoru;        // 1 = predicted taken
        veri_t    ps;
        veri_t    br;            // sign extended B immediate
        veri_t    rs1;
        veri_t    rs2;
    } coz_cikis_s;

    // execute -> result
    // operands are dropped here, only the flags travel on
    typedef struct packed {
        logic     gecerli;
        logic     blok_aktif;
        dal_tur_e dal_buy_turu;
        logic     ongoru;
        veri_t    ps;
        veri_t    br;
        logic     esit_mi;           // rs1 == rs2
        logic     buyuk_mu;          // rs1 > rs2 signed
        logic     buyuk_mu_unsigned; // rs1 > rs2 unsigned
    } yurut_cikis_s;

endpackage
